/* bench/video_out_checker.sv */
// needs one reset edge before it arms; compares DUT outputs at the falling edge only
`timescale 1ns/1ps
`default_nettype none

module video_out_checker import video_pkg::*; (
    input  wire logic clk,
    input  wire logic reset_i,
    input  wire logic bar_enable_i,
    input  wire rgb_t border_color_i,
    input  wire rgb_t rgb_i,
    input  wire logic hsync_i,
    input  wire logic vsync_i,
    input  wire logic de_i,
    input  wire logic frame_start_i,
    output int        mismatch_count_o,
    output int        other_count_o,
    output int        frame_count_o
);

    // expected pin values for one cycle
    typedef struct packed {
        rgb_t rgb;
        logic hsync;
        logic vsync;
        logic de;
        logic frame_start;
    } pins_t;

    int      mismatches = 0;
    int      others = 0;
    int      frames = 0;
    logic    armed = 1'b0;
    // model raster position and the timing that belongs to it
    int      h;
    int      v;
    raster_t timing_now;
    // generator stage, one cycle behind the counters
    rgb_t    bar_q;
    logic    border_q;
    raster_t timing_q;
    // pins, two cycles behind the counters
    pins_t   expected_q;
    // per frame bookkeeping
    int      de_cycles;
    int      pulse_gap;
    logic    pulse_seen;

    assign mismatch_count_o = mismatches;
    assign other_count_o    = others;
    assign frame_count_o    = frames;

    // porch and sync rules; strobes are off for the reset position
    function automatic raster_t timing_at(input int hh, input int vv, input logic strobes);
        raster_t r;
        r.hsync = ((hh >= H_FRONT_PORCH) && (hh < H_FRONT_PORCH + H_SYNC_PULSE)) ?
                  H_SYNC_POLARITY : ~H_SYNC_POLARITY;
        r.vsync = ((vv >= VIS_HEIGHT + V_FRONT_PORCH) &&
                   (vv < VIS_HEIGHT + V_FRONT_PORCH + V_SYNC_PULSE)) ?
                  V_SYNC_POLARITY : ~V_SYNC_POLARITY;
        r.dv_de        = (hh >= H_OFFSCREEN) && (vv < VIS_HEIGHT);
        r.end_of_line  = strobes && (hh == 0);
        r.end_of_frame = strobes && (hh == 0) && (vv == 0);
        return r;
    endfunction

    // white yellow cyan green magenta red blue black, left to right
    function automatic rgb_t bar_at(input int hh, input logic enable);
        if (!enable || (hh < H_OFFSCREEN)) begin
            return '0;
        end
        case ((hh - H_OFFSCREEN) / BAR_WIDTH)
            0: return 12'hfff;
            1: return 12'hff0;
            2: return 12'h0ff;
            3: return 12'h0f0;
            4: return 12'hf0f;
            5: return 12'hf00;
            6: return 12'h00f;
            default: return 12'h000;
        endcase
    endfunction

    // outer ring of the visible window
    function automatic logic border_at(input int hh, input int vv);
        return (hh >= H_OFFSCREEN) && (vv < VIS_HEIGHT) &&
               ((hh == H_OFFSCREEN) || (hh == TOTAL_WIDTH - 1) ||
                (vv == 0) || (vv == VIS_HEIGHT - 1));
    endfunction

    task automatic check_value(input string name, input logic [31:0] expected,
                               input logic [31:0] actual);
        if (actual !== expected) begin
            mismatches++;
            $display("Mismatch %s expected %0h got %0h", name, expected, actual);
        end
    endtask

    // model steps on the rising edge with the inputs the DUT sees there
    always @(posedge clk) begin
        if (reset_i) begin
            armed      = 1'b1;
            h          = 0;
            v          = 0;
            timing_now = timing_at(0, 0, 1'b0);
            bar_q      = '0;
            border_q   = 1'b0;
            timing_q   = timing_now;
            expected_q = {12'h000, timing_now.hsync, timing_now.vsync, 1'b0, 1'b0};
        end else if (armed) begin
            // border lies over the bars, black outside enable
            expected_q.rgb         = timing_q.dv_de ? (border_q ? border_color_i : bar_q) : '0;
            expected_q.hsync       = timing_q.hsync;
            expected_q.vsync       = timing_q.vsync;
            expected_q.de          = timing_q.dv_de;
            expected_q.frame_start = timing_q.end_of_frame;
            bar_q    = bar_at(h, bar_enable_i);
            border_q = border_at(h, v);
            timing_q = timing_now;
            h = h + 1;
            if (h == TOTAL_WIDTH) begin
                h = 0;
                v = (v + 1) % TOTAL_HEIGHT;
            end
            timing_now = timing_at(h, v, 1'b1);
        end
    end

    // outputs have settled by the falling edge
    always @(negedge clk) begin
        if (armed) begin
            if ($isunknown({rgb_i, hsync_i, vsync_i, de_i, frame_start_i})) begin
                others++;
                $display("DUT outputs carry unknown bits at %0t", $time);
            end
            check_value("rgb_o", 32'(expected_q.rgb), 32'(rgb_i));
            check_value("hsync_o", 32'(expected_q.hsync), 32'(hsync_i));
            check_value("vsync_o", 32'(expected_q.vsync), 32'(vsync_i));
            check_value("de_o", 32'(expected_q.de), 32'(de_i));
            check_value("frame_start_o", 32'(expected_q.frame_start), 32'(frame_start_i));
        end
        if (reset_i) begin
            de_cycles  = 0;
            pulse_gap  = 0;
            pulse_seen = 1'b0;
        end else if (armed) begin
            pulse_gap++;
            if (de_i) begin
                de_cycles++;
            end
            // whole frame of enabled pixels between strobes, one frame apart
            if (frame_start_i) begin
                frames++;
                check_value("de_cycles", 32'(VIS_WIDTH * VIS_HEIGHT), 32'(de_cycles));
                if (pulse_seen) begin
                    check_value("frame_period", 32'(TOTAL_WIDTH * TOTAL_HEIGHT), 32'(pulse_gap));
                end
                pulse_seen = 1'b1;
                pulse_gap  = 0;
                de_cycles  = 0;
            end
        end
    end

endmodule

`default_nettype wire

/* bench/video_out_tb.sv */
// 100 ns clock; inputs move 1 ns after a rising edge and only on the cycle after a frame start
`timescale 1ns/1ps
`default_nettype none

module video_out_tb import video_pkg::*; ();

    localparam int ROWS         = 6;
    localparam int FRAME_CYCLES = TOTAL_WIDTH * TOTAL_HEIGHT;

    // one stimulus row, held for whole frames
    typedef struct packed {
        logic       bar_enable;
        rgb_t       border_color;
        logic       random_color;
        logic [3:0] frames;
    } stim_row_t;

    logic clk;
    logic reset;
    logic bar_enable;
    rgb_t border_color;
    rgb_t rgb;
    logic hsync;
    logic vsync;
    logic de;
    logic frame_start;
    int   mismatch_count;
    int   other_count;
    int   frame_count;

    // bar enable, border colour, random colour, frames
    function automatic stim_row_t stim_row(input int idx);
        case (idx)
            0: return {1'b1, 12'hf00, 1'b0, 4'd1};
            1: return {1'b0, 12'h0f0, 1'b0, 4'd1};
            2: return {1'b1, 12'h000, 1'b1, 4'd1};
            // black border over the bars
            3: return {1'b1, 12'h000, 1'b0, 4'd1};
            4: return {1'b0, 12'h000, 1'b1, 4'd1};
            default: return {1'b1, 12'hfff, 1'b0, 4'd1};
        endcase
    endfunction

    task automatic apply_row(input stim_row_t row);
        bar_enable   = row.bar_enable;
        border_color = row.border_color;
        if (row.random_color) begin
            border_color = 12'($urandom());
        end
    endtask

    // returns at the falling edge where the strobe is seen
    task automatic wait_frame_start();
        @(negedge clk);
        while (!frame_start) begin
            @(negedge clk);
        end
    endtask

    task automatic print_summary();
        $display("summary: %0d mismatches, %0d other errors, %0d frame starts",
                 mismatch_count, other_count, frame_count);
    endtask

    video_out_top dut0 (
        .clk            (clk),
        .reset_i        (reset),
        .bar_enable_i   (bar_enable),
        .border_color_i (border_color),
        .rgb_o          (rgb),
        .hsync_o        (hsync),
        .vsync_o        (vsync),
        .de_o           (de),
        .frame_start_o  (frame_start)
    );

    video_out_checker check0 (
        .clk              (clk),
        .reset_i          (reset),
        .bar_enable_i     (bar_enable),
        .border_color_i   (border_color),
        .rgb_i            (rgb),
        .hsync_i          (hsync),
        .vsync_i          (vsync),
        .de_i             (de),
        .frame_start_i    (frame_start),
        .mismatch_count_o (mismatch_count),
        .other_count_o    (other_count),
        .frame_count_o    (frame_count)
    );

    initial begin
        clk = 1'b0;
        forever begin
            #50 clk = ~clk;
        end
    end

    initial begin : stimulus
        stim_row_t row;
        int        idx;
        int        frame_idx;
        void'($urandom(32'hc7cf8631));
        reset        = 1'b1;
        bar_enable   = 1'b0;
        border_color = '0;
        repeat (4) @(posedge clk);
        #1;
        reset = 1'b0;
        for (idx = 0; idx < ROWS; idx++) begin
            row = stim_row(idx);
            apply_row(row);
            for (frame_idx = 0; frame_idx < int'(row.frames); frame_idx++) begin
                wait_frame_start();
            end
            // next row starts on the cycle after the strobe
            @(posedge clk);
            #1;
        end
        print_summary();
        if ((mismatch_count == 0) && (other_count == 0)) begin
            $display("Testbench passed");
        end else begin
            $display("Testbench failed");
        end
        $finish;
    end

    // limit is every table frame plus one spare frame and a little slack
    initial begin : watchdog
        stim_row_t row;
        int        idx;
        int        limit;
        int        cycles;
        limit = FRAME_CYCLES + 20;
        for (idx = 0; idx < ROWS; idx++) begin
            row   = stim_row(idx);
            limit = limit + int'(row.frames) * FRAME_CYCLES;
        end
        cycles = 0;
        while (cycles < limit) begin
            @(posedge clk);
            cycles++;
        end
        $display("timeout: %0d cycles went by before the stimulus table finished", limit);
        print_summary();
        $display("Testbench failed");
        $finish;
    end

endmodule

`default_nettype wire

/* files.f */
hdl/video_pkg.sv
hdl/video_timing.sv
hdl/color_bar_gen.sv
hdl/border_gen.sv
hdl/pixel_combine.sv
hdl/video_out_top.sv
bench/video_out_checker.sv
bench/video_out_tb.sv

/* hdl/border_gen.sv */
// one cycle from counters to flag; flags only the outer ring of the visible area
`timescale 1ns/1ps
`default_nettype none

module border_gen import video_pkg::*; (
    input  wire logic  clk,
    input  wire logic  reset_i,
    input  wire hres_t h_count_i,
    input  wire vres_t v_count_i,
    output logic       on_border_o
);

    logic visible;
    logic edge_col;
    logic edge_line;

    always_comb begin
        // inside the visible window at all
        visible   = (h_count_i >= hres_t'(H_OFFSCREEN)) && (v_count_i < vres_t'(VIS_HEIGHT));
        // first or last visible column
        edge_col  = (h_count_i == hres_t'(H_OFFSCREEN)) ||
                    (h_count_i == hres_t'(TOTAL_WIDTH - 1));
        // top or bottom visible line
        edge_line = (v_count_i == '0) || (v_count_i == vres_t'(VIS_HEIGHT - 1));
    end

    always_ff @(posedge clk) begin
        if (reset_i) begin
            on_border_o <= 1'b0;
        end else begin
            on_border_o <= visible && (edge_col || edge_line);
        end
    end

    // never starts a border on a blanking line
    assert property (@(posedge clk) disable iff (reset_i)
        $rose(on_border_o) |-> ($past(v_count_i) < vres_t'(VIS_HEIGHT)));

endmodule

`default_nettype wire

/* hdl/color_bar_gen.sv */
// one cycle from h_count to bar colour; bar width is VIS_WIDTH/8, no vertical dependence
`timescale 1ns/1ps
`default_nettype none

module color_bar_gen import video_pkg::*; (
    input  wire logic  clk,
    input  wire logic  reset_i,
    input  wire hres_t h_count_i,
    input  wire logic  bar_enable_i,
    output rgb_t       bar_rgb_o
);

    hres_t      vis_col;
    logic [2:0] bar_idx;
    rgb_t       bar_color;

    always_comb begin
        // column within the visible part of the line
        vis_col = h_count_i - hres_t'(H_OFFSCREEN);
        bar_idx = 3'(vis_col / hres_t'(BAR_WIDTH));

        // classic bar order, full scale channels
        case (bar_idx)
            3'd0: bar_color = '{r: 4'hf, g: 4'hf, b: 4'hf};
            3'd1: bar_color = '{r: 4'hf, g: 4'hf, b: 4'h0};
            3'd2: bar_color = '{r: 4'h0, g: 4'hf, b: 4'hf};
            3'd3: bar_color = '{r: 4'h0, g: 4'hf, b: 4'h0};
            3'd4: bar_color = '{r: 4'hf, g: 4'h0, b: 4'hf};
            3'd5: bar_color = '{r: 4'hf, g: 4'h0, b: 4'h0};
            3'd6: bar_color = '{r: 4'h0, g: 4'h0, b: 4'hf};
            3'd7: bar_color = '{r: 4'h0, g: 4'h0, b: 4'h0};
        endcase

        // black in the porch/sync columns or when bars are switched off
        if (!bar_enable_i || (h_count_i < hres_t'(H_OFFSCREEN))) begin
            bar_color = '0;
        end
    end

    always_ff @(posedge clk) begin
        if (reset_i) begin
            bar_rgb_o <= '0;
        end else begin
            bar_rgb_o <= bar_color;
        end
    end

endmodule

`default_nettype wire

/* hdl/pixel_combine.sv */
// adds one cycle; expects generators one cycle behind raster_i, outputs two behind counters
`timescale 1ns/1ps
`default_nettype none

module pixel_combine import video_pkg::*; (
    input  wire logic    clk,
    input  wire logic    reset_i,
    input  wire raster_t raster_i,
    input  wire rgb_t    bar_rgb_i,
    input  wire logic    on_border_i,
    input  wire rgb_t    border_color_i,
    output rgb_t         rgb_o,
    output logic         hsync_o,
    output logic         vsync_o,
    output logic         de_o,
    output logic         frame_start_o
);

    // raster_q1 matches the generator outputs, raster_q2 matches rgb_o
    raster_t raster_q1;
    raster_t raster_q2;
    rgb_t    pixel;

    // idle raster, syncs inactive and nothing else set
    localparam raster_t RASTER_IDLE = '{
        hsync:        ~H_SYNC_POLARITY,
        vsync:        ~V_SYNC_POLARITY,
        dv_de:        1'b0,
        end_of_frame: 1'b0,
        end_of_line:  1'b0
    };

    always_comb begin
        // border lies on top of the bars
        pixel = on_border_i ? border_color_i : bar_rgb_i;
        // black outside display enable
        if (!raster_q1.dv_de) begin
            pixel = '0;
        end
    end

    always_ff @(posedge clk) begin
        if (reset_i) begin
            raster_q1 <= RASTER_IDLE;
            raster_q2 <= RASTER_IDLE;
            rgb_o     <= '0;
        end else begin
            raster_q1 <= raster_i;
            raster_q2 <= raster_q1;
            rgb_o     <= pixel;
        end
    end

    assign hsync_o       = raster_q2.hsync;
    assign vsync_o       = raster_q2.vsync;
    assign de_o          = raster_q2.dv_de;
    assign frame_start_o = raster_q2.end_of_frame;

    // blanked pixels carry no colour
    assert property (@(posedge clk) !de_o |-> (rgb_o == '0));

    // a frame always begins on a line start
    assert property (@(posedge clk) disable iff (reset_i)
        frame_start_o |-> raster_q2.end_of_line);

endmodule

`default_nettype wire

/* hdl/video_out_top.sv */
// wiring only; every output lags the raster counters by two clocks
`timescale 1ns/1ps
`default_nettype none

module video_out_top import video_pkg::*; (
    input  wire logic clk,
    input  wire logic reset_i,
    input  wire logic bar_enable_i,
    input  wire rgb_t border_color_i,
    output rgb_t      rgb_o,
    output logic      hsync_o,
    output logic      vsync_o,
    output logic      de_o,
    output logic      frame_start_o
);

    hres_t   h_count;
    vres_t   v_count;
    raster_t raster;
    rgb_t    bar_rgb;
    logic    on_border;

    video_timing timing0 (
        .clk         (clk),
        .reset_i     (reset_i),
        .h_count_o   (h_count),
        .v_count_o   (v_count),
        .h_visible_o (),
        .raster_o    (raster)
    );

    color_bar_gen bars0 (
        .clk          (clk),
        .reset_i      (reset_i),
        .h_count_i    (h_count),
        .bar_enable_i (bar_enable_i),
        .bar_rgb_o    (bar_rgb)
    );

    border_gen border0 (
        .clk         (clk),
        .reset_i     (reset_i),
        .h_count_i   (h_count),
        .v_count_i   (v_count),
        .on_border_o (on_border)
    );

    pixel_combine combine0 (
        .clk            (clk),
        .reset_i        (reset_i),
        .raster_i       (raster),
        .bar_rgb_i      (bar_rgb),
        .on_border_i    (on_border),
        .border_color_i (border_color_i),
        .rgb_o          (rgb_o),
        .hsync_o        (hsync_o),
        .vsync_o        (vsync_o),
        .de_o           (de_o),
        .frame_start_o  (frame_start_o)
    );

endmodule

`default_nettype wire

/* hdl/video_pkg.sv */
// fixed tiny raster mode for simulation only; no pll, no run-time mode switch, negative syncs
`default_nettype none

package video_pkg;

    // horizontal mode, porches and sync lead the line and the visible pixels come last
    localparam int VIS_WIDTH     = 16;
    localparam int H_FRONT_PORCH = 2;
    localparam int H_SYNC_PULSE  = 3;
    localparam int H_BACK_PORCH  = 3;
    localparam int TOTAL_WIDTH   = H_FRONT_PORCH + H_SYNC_PULSE + H_BACK_PORCH + VIS_WIDTH;
    // h_count of the first visible pixel
    localparam int H_OFFSCREEN   = TOTAL_WIDTH - VIS_WIDTH;

    // vertical mode, visible lines first and blanking lines at the bottom
    localparam int VIS_HEIGHT    = 8;
    localparam int V_FRONT_PORCH = 1;
    localparam int V_SYNC_PULSE  = 2;
    localparam int V_BACK_PORCH  = 1;
    localparam int TOTAL_HEIGHT  = VIS_HEIGHT + V_FRONT_PORCH + V_SYNC_PULSE + V_BACK_PORCH;

    // active sync levels
    localparam logic H_SYNC_POLARITY = 1'b0;
    localparam logic V_SYNC_POLARITY = 1'b0;

    // eight colour bars across the visible width
    localparam int BAR_WIDTH = VIS_WIDTH / 8;

    // raster counters, sized for TOTAL_WIDTH and TOTAL_HEIGHT
    typedef logic [4:0] hres_t;
    typedef logic [3:0] vres_t;

    // 4 bits per channel
    typedef struct packed {
        logic [3:0] r;
        logic [3:0] g;
        logic [3:0] b;
    } rgb_t;

    // timing bundle from the raster generator to the pixel combiner
    typedef struct packed {
        logic hsync;
        logic vsync;
        // display enable
        logic dv_de;
        // first pixel of a new frame
        logic end_of_frame;
        // first pixel of a new line
        logic end_of_line;
    } raster_t;

endpackage

`default_nettype wire

/* hdl/video_timing.sv */
// all outputs registered and aligned to h_count/v_count; mode fixed by video_pkg localparams
`timescale 1ns/1ps
`default_nettype none

module video_timing import video_pkg::*; (
    input  wire logic clk,
    input  wire logic reset_i,
    output hres_t     h_count_o,
    output vres_t     v_count_o,
    output logic      h_visible_o,
    output raster_t   raster_o
);

    // both machines start in state 0 so reset lands on pixel 0 of line 0
    typedef enum logic [1:0] {
        H_FRONT   = 2'b00,
        H_SYNC    = 2'b01,
        H_BACK    = 2'b10,
        H_VISIBLE = 2'b11
    } h_state_t;

    typedef enum logic [1:0] {
        V_VISIBLE = 2'b00,
        V_FRONT   = 2'b01,
        V_SYNC    = 2'b10,
        V_BACK    = 2'b11
    } v_state_t;

    h_state_t h_state;
    h_state_t h_state_next;
    v_state_t v_state;
    v_state_t v_state_next;

    hres_t    h_count;
    hres_t    h_count_next;
    hres_t    h_match;
    vres_t    v_count;
    vres_t    v_count_next;
    vres_t    v_match;

    logic     end_of_line_next;
    raster_t  raster_next;
    raster_t  raster_q;

    // last h_count of each horizontal interval
    always_comb begin
        case (h_state)
            H_FRONT:   h_match = hres_t'(H_FRONT_PORCH - 1);
            H_SYNC:    h_match = hres_t'(H_FRONT_PORCH + H_SYNC_PULSE - 1);
            H_BACK:    h_match = hres_t'(H_OFFSCREEN - 1);
            H_VISIBLE: h_match = hres_t'(TOTAL_WIDTH - 1);
        endcase
    end

    // last line of each vertical interval
    always_comb begin
        case (v_state)
            V_VISIBLE: v_match = vres_t'(VIS_HEIGHT - 1);
            V_FRONT:   v_match = vres_t'(VIS_HEIGHT + V_FRONT_PORCH - 1);
            V_SYNC:    v_match = vres_t'(VIS_HEIGHT + V_FRONT_PORCH + V_SYNC_PULSE - 1);
            V_BACK:    v_match = vres_t'(TOTAL_HEIGHT - 1);
        endcase
    end

    // state steps when the counter hits the interval end, wrapping visible back to front
    always_comb begin
        h_state_next = h_state;
        if (h_count == h_match) begin
            h_state_next = h_state_t'(h_state + 2'd1);
        end
    end

    // line wraps when the visible interval ends
    assign end_of_line_next = (h_state == H_VISIBLE) && (h_state_next == H_FRONT);

    // vertical machine only moves on a line boundary
    always_comb begin
        v_state_next = v_state;
        if (end_of_line_next && (v_count == v_match)) begin
            v_state_next = v_state_t'(v_state + 2'd1);
        end
    end

    // counters follow the next state so they line up with the registered outputs
    always_comb begin
        h_count_next = h_count + 1'b1;
        v_count_next = v_count;
        if (end_of_line_next) begin
            h_count_next = '0;
            v_count_next = v_count + 1'b1;
            if ((v_state == V_BACK) && (v_state_next == V_VISIBLE)) begin
                v_count_next = '0;
            end
        end
    end

    // outputs decoded from the next state, then registered with the counters
    always_comb begin
        raster_next.hsync        = (h_state_next == H_SYNC) ? H_SYNC_POLARITY : ~H_SYNC_POLARITY;
        raster_next.vsync        = (v_state_next == V_SYNC) ? V_SYNC_POLARITY : ~V_SYNC_POLARITY;
        raster_next.dv_de        = (h_state_next == H_VISIBLE) && (v_state_next == V_VISIBLE);
        raster_next.end_of_line  = end_of_line_next;
        raster_next.end_of_frame = end_of_line_next && (v_state == V_BACK) &&
                                   (v_state_next == V_VISIBLE);
    end

    always_ff @(posedge clk) begin
        if (reset_i) begin
            h_state              <= H_FRONT;
            v_state              <= V_VISIBLE;
            h_count              <= '0;
            v_count              <= '0;
            // syncs idle, no enable and no strobes while in reset
            raster_q.hsync        <= ~H_SYNC_POLARITY;
            raster_q.vsync        <= ~V_SYNC_POLARITY;
            raster_q.dv_de        <= 1'b0;
            raster_q.end_of_frame <= 1'b0;
            raster_q.end_of_line  <= 1'b0;
        end else begin
            h_state  <= h_state_next;
            v_state  <= v_state_next;
            h_count  <= h_count_next;
            v_count  <= v_count_next;
            raster_q <= raster_next;
        end
    end

    assign h_count_o   = h_count;
    assign v_count_o   = v_count;
    assign h_visible_o = (h_state == H_VISIBLE);
    assign raster_o    = raster_q;

    // enable only on the visible columns of the horizontal counter
    assert property (@(posedge clk) disable iff (reset_i)
        raster_q.dv_de |-> (h_count >= hres_t'(H_OFFSCREEN)));

    // horizontal counter wraps before TOTAL_WIDTH
    assert property (@(posedge clk) h_count < hres_t'(TOTAL_WIDTH));

endmodule

`default_nettype wire

/* run_sim.sh */
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -f files.f --top-module video_out_tb -o video_out_sim

# an assertion stop gives a failing exit code, so the output is captured either way
sim_output=$(./obj_dir/video_out_sim) || true
echo "$sim_output"

if echo "$sim_output" | grep -qx "Testbench passed"; then
    exit 0
fi
exit 1
